//--- rtl/dual_config.svh
`ifndef DUAL_CONFIG_SVH
`define DUAL_CONFIG_SVH

// integer datapath width
`define DUAL_XLEN 32

// architectural register file
`define DUAL_REG_COUNT 32
`define DUAL_REG_AW 5

`endif

//--- rtl/dual_pkg.sv
`include "dual_config.svh"

package dual_pkg;

    typedef logic [`DUAL_XLEN-1:0]   word_t;
    typedef logic [`DUAL_REG_AW-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,   // signed compare
        ALU_SLL = 3'd6,
        ALU_SRL = 3'd7
    } alu_op_e;

    typedef enum logic {
        SPLIT_WHOLE  = 1'b0,
        SPLIT_SECOND = 1'b1   // slot 1 of a split pair still to go
    } split_state_e;

    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        logic      use_imm;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
    } issue_op_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } wb_port_t;

endpackage

//--- rtl/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  dual_pkg::alu_op_e op,
    input  dual_pkg::word_t   a,
    input  dual_pkg::word_t   b,
    output dual_pkg::word_t   y
);
    import dual_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;

    assign shamt     = b[4:0];   // only low 5 bits shift
    assign lt_signed = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            ALU_ADD: begin
                y = a + b;
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_AND: begin
                y = a & b;
            end
            ALU_OR: begin
                y = a | b;
            end
            ALU_XOR: begin
                y = a ^ b;
            end
            ALU_SLT: begin
                y = word_t'(lt_signed);
            end
            ALU_SLL: begin
                y = a << shamt;
            end
            ALU_SRL: begin
                y = a >> shamt;   // logical
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps
`include "dual_config.svh"

module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  dual_pkg::reg_addr_t r_addr_1,
    input  dual_pkg::reg_addr_t r_addr_2,
    input  dual_pkg::reg_addr_t r_addr_3,
    input  dual_pkg::reg_addr_t r_addr_4,
    output dual_pkg::word_t     r_data_1,
    output dual_pkg::word_t     r_data_2,
    output dual_pkg::word_t     r_data_3,
    output dual_pkg::word_t     r_data_4,
    input  dual_pkg::wb_port_t  w_port_1,
    input  dual_pkg::wb_port_t  w_port_2
);
    import dual_pkg::*;

    word_t mem [`DUAL_REG_COUNT];

    // a read sees what the array will hold after this cycle's writes
    function automatic word_t read_port(
        input reg_addr_t addr,
        input word_t     stored,
        input wb_port_t  wp1,
        input wb_port_t  wp2
    );
        word_t val;
        val = stored;
        if (wp1.en && (wp1.addr == addr)) begin
            val = wp1.data;
        end
        if (wp2.en && (wp2.addr == addr)) begin
            val = wp2.data;   // port 2 checked last and wins
        end
        if (addr == '0) begin
            val = '0;         // x0 reads zero
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DUAL_REG_COUNT; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (w_port_1.en && (w_port_1.addr != '0)) begin
                mem[w_port_1.addr] <= w_port_1.data;
            end
            if (w_port_2.en && (w_port_2.addr != '0)) begin
                mem[w_port_2.addr] <= w_port_2.data;   // port 2 lands on a shared addr
            end
        end
    end

    assign r_data_1 = read_port(r_addr_1, mem[r_addr_1], w_port_1, w_port_2);
    assign r_data_2 = read_port(r_addr_2, mem[r_addr_2], w_port_1, w_port_2);
    assign r_data_3 = read_port(r_addr_3, mem[r_addr_3], w_port_1, w_port_2);
    assign r_data_4 = read_port(r_addr_4, mem[r_addr_4], w_port_1, w_port_2);

    a_wp1_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        w_port_1.en |-> !$isunknown(w_port_1.addr)
    ) else $error("regfile: write port 1 address unknown");

    a_wp2_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        w_port_2.en |-> !$isunknown(w_port_2.addr)
    ) else $error("regfile: write port 2 address unknown");

endmodule

//--- rtl/pair_issue.sv
`timescale 1ns/1ps

module pair_issue (
    input  logic                clk,
    input  logic                rst_n,
    input  dual_pkg::issue_op_t in_op_0,
    input  dual_pkg::issue_op_t in_op_1,
    output dual_pkg::issue_op_t iss_0,
    output dual_pkg::issue_op_t iss_1,
    output logic                hold
);
    import dual_pkg::*;

    split_state_e state_q;
    split_state_e state_d;
    logic         rd_live;
    logic         rs1_hit;
    logic         rs2_hit;
    logic         dep;

    assign rd_live = in_op_0.valid && (in_op_0.rd != '0);
    assign rs1_hit = (in_op_1.rs1 == in_op_0.rd);
    assign rs2_hit = !in_op_1.use_imm && (in_op_1.rs2 == in_op_0.rd);   // imm form has no rs2
    assign dep     = rd_live && in_op_1.valid && (rs1_hit || rs2_hit);

    always_comb begin
        iss_0   = in_op_0;
        iss_1   = in_op_1;
        hold    = 1'b0;
        state_d = state_q;
        case (state_q)
            SPLIT_WHOLE: begin
                if (dep) begin
                    iss_1.valid = 1'b0;   // younger op waits
                    hold        = 1'b1;
                    state_d     = SPLIT_SECOND;
                end
            end
            SPLIT_SECOND: begin
                iss_0.valid = 1'b0;       // slot 0 went last cycle
                state_d     = SPLIT_WHOLE;
            end
            default: begin
                state_d = SPLIT_WHOLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= SPLIT_WHOLE;
        end else begin
            state_q <= state_d;
        end
    end

    // a split never lasts more than one extra cycle
    a_hold_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        hold |=> !hold
    ) else $error("pair_issue: hold high two cycles in a row");

endmodule

//--- rtl/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    input  dual_pkg::word_t     r_data_1,
    input  dual_pkg::word_t     r_data_2,
    input  dual_pkg::word_t     r_data_3,
    input  dual_pkg::word_t     r_data_4,
    input  dual_pkg::issue_op_t iss_0,
    input  dual_pkg::issue_op_t iss_1,
    input  dual_pkg::wb_port_t  ex_fwd_0,
    input  dual_pkg::wb_port_t  ex_fwd_1,
    output dual_pkg::word_t     opnd_1,
    output dual_pkg::word_t     opnd_2,
    output dual_pkg::word_t     opnd_3,
    output dual_pkg::word_t     opnd_4
);
    import dual_pkg::*;

    // execute result beats register file, slot 1 beats slot 0
    function automatic word_t pick(
        input reg_addr_t rs,
        input word_t     rf_word,
        input wb_port_t  f0,
        input wb_port_t  f1
    );
        word_t val;
        val = rf_word;
        if (rs != '0) begin
            if (f1.en && (f1.addr == rs)) begin
                val = f1.data;
            end else if (f0.en && (f0.addr == rs)) begin
                val = f0.data;
            end
        end
        return val;
    endfunction

    assign opnd_1 = pick(iss_0.rs1, r_data_1, ex_fwd_0, ex_fwd_1);
    assign opnd_2 = pick(iss_0.rs2, r_data_2, ex_fwd_0, ex_fwd_1);
    assign opnd_3 = pick(iss_1.rs1, r_data_3, ex_fwd_0, ex_fwd_1);
    assign opnd_4 = pick(iss_1.rs2, r_data_4, ex_fwd_0, ex_fwd_1);

endmodule

//--- rtl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  dual_pkg::issue_op_t iss_0,
    input  dual_pkg::issue_op_t iss_1,
    input  dual_pkg::word_t     opnd_1,
    input  dual_pkg::word_t     opnd_2,
    input  dual_pkg::word_t     opnd_3,
    input  dual_pkg::word_t     opnd_4,
    output dual_pkg::wb_port_t  ex_fwd_0,
    output dual_pkg::wb_port_t  ex_fwd_1,
    output dual_pkg::wb_port_t  wb_0,
    output dual_pkg::wb_port_t  wb_1
);
    import dual_pkg::*;

    issue_op_t iss    [2];
    word_t     opnd_a [2];
    word_t     opnd_b [2];
    wb_port_t  fwd    [2];
    wb_port_t  wb     [2];

    assign iss[0]    = iss_0;
    assign iss[1]    = iss_1;
    assign opnd_a[0] = opnd_1;
    assign opnd_b[0] = opnd_2;
    assign opnd_a[1] = opnd_3;
    assign opnd_b[1] = opnd_4;

    for (genvar s = 0; s < 2; s++) begin : g_slot
        logic      ex_vld;
        issue_op_t ex_op;
        word_t     ex_a;
        word_t     ex_b;
        word_t     alu_b;
        word_t     alu_y;
        logic      wb_en;
        reg_addr_t wb_addr;
        word_t     wb_data;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                ex_vld <= 1'b0;
                wb_en  <= 1'b0;
            end else begin
                ex_vld <= iss[s].valid;
                wb_en  <= ex_vld;   // x0 writes still strobe
            end
        end

        always_ff @(posedge clk) begin
            ex_op   <= iss[s];
            ex_a    <= opnd_a[s];
            ex_b    <= opnd_b[s];
            wb_addr <= ex_op.rd;
            wb_data <= alu_y;
        end

        assign alu_b = ex_op.use_imm ? ex_op.imm : ex_b;

        int_alu alu_i (
            .op (ex_op.op),
            .a  (ex_a),
            .b  (alu_b),
            .y  (alu_y)
        );

        assign fwd[s] = '{en: ex_vld, addr: ex_op.rd, data: alu_y};
        assign wb[s]  = '{en: wb_en, addr: wb_addr, data: wb_data};

        a_wb_data_known: assert property (
            @(posedge clk) disable iff (!rst_n)
            wb_en |-> !$isunknown(wb_data)
        ) else $error("exec_stage: writeback data unknown in slot %0d", s);
    end

    assign ex_fwd_0 = fwd[0];
    assign ex_fwd_1 = fwd[1];
    assign wb_0     = wb[0];
    assign wb_1     = wb[1];

endmodule

//--- rtl/dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core (
    input  logic                clk,
    input  logic                rst_n,
    input  dual_pkg::issue_op_t in_op_0,
    input  dual_pkg::issue_op_t in_op_1,
    output logic                hold,
    output dual_pkg::wb_port_t  wb_0,
    output dual_pkg::wb_port_t  wb_1
);
    import dual_pkg::*;

    issue_op_t iss_0;
    issue_op_t iss_1;
    word_t     r_data_1;
    word_t     r_data_2;
    word_t     r_data_3;
    word_t     r_data_4;
    word_t     opnd_1;
    word_t     opnd_2;
    word_t     opnd_3;
    word_t     opnd_4;
    wb_port_t  ex_fwd_0;
    wb_port_t  ex_fwd_1;

    pair_issue pair_issue_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_op_0 (in_op_0),
        .in_op_1 (in_op_1),
        .iss_0   (iss_0),
        .iss_1   (iss_1),
        .hold    (hold)
    );

    regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .r_addr_1 (iss_0.rs1),
        .r_addr_2 (iss_0.rs2),
        .r_addr_3 (iss_1.rs1),
        .r_addr_4 (iss_1.rs2),
        .r_data_1 (r_data_1),
        .r_data_2 (r_data_2),
        .r_data_3 (r_data_3),
        .r_data_4 (r_data_4),
        .w_port_1 (wb_0),
        .w_port_2 (wb_1)   // younger slot on port 2
    );

    operand_bypass operand_bypass_i (
        .r_data_1 (r_data_1),
        .r_data_2 (r_data_2),
        .r_data_3 (r_data_3),
        .r_data_4 (r_data_4),
        .iss_0    (iss_0),
        .iss_1    (iss_1),
        .ex_fwd_0 (ex_fwd_0),
        .ex_fwd_1 (ex_fwd_1),
        .opnd_1   (opnd_1),
        .opnd_2   (opnd_2),
        .opnd_3   (opnd_3),
        .opnd_4   (opnd_4)
    );

    exec_stage exec_stage_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .iss_0    (iss_0),
        .iss_1    (iss_1),
        .opnd_1   (opnd_1),
        .opnd_2   (opnd_2),
        .opnd_3   (opnd_3),
        .opnd_4   (opnd_4),
        .ex_fwd_0 (ex_fwd_0),
        .ex_fwd_1 (ex_fwd_1),
        .wb_0     (wb_0),
        .wb_1     (wb_1)
    );

endmodule

//--- test/tb_dual_issue.sv
`timescale 1ns/1ps

module tb_dual_issue;
    import dual_pkg::*;

    logic      clk;
    logic      rst_n;
    issue_op_t in_op_0;
    issue_op_t in_op_1;
    logic      hold;
    wb_port_t  wb_0;
    wb_port_t  wb_1;

    string     line_name  [$];
    logic      line_chain [$];
    issue_op_t line_op0   [$];
    issue_op_t line_op1   [$];
    wb_port_t  exp_q      [$];   // expected writebacks in sequential order
    string     exp_name   [$];
    int        exp_slot   [$];
    wb_port_t  seen       [$];
    int        value_errs;
    int        other_errs;
    logic      loaded;

    dual_issue_core dual_issue_core_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_op_0 (in_op_0),
        .in_op_1 (in_op_1),
        .hold    (hold),
        .wb_0    (wb_0),
        .wb_1    (wb_1)
    );

    always #20 clk = ~clk;

    // every wb strobe with slot 0 first
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_0.en) begin
                seen.push_back(wb_0);
            end
            if (wb_1.en) begin
                seen.push_back(wb_1);
            end
        end
    end

    function automatic issue_op_t make_op(
        input logic       v,
        input logic [2:0] op,
        input logic       ui,
        input reg_addr_t  rd,
        input reg_addr_t  rs1,
        input reg_addr_t  rs2,
        input word_t      imm
    );
        issue_op_t o;
        o.valid   = v;
        o.op      = alu_op_e'(op);
        o.use_imm = ui;
        o.rd      = rd;
        o.rs1     = rs1;
        o.rs2     = rs2;
        o.imm     = imm;
        return o;
    endfunction

    // younger op reads a live destination of the older one
    function automatic logic splits(input issue_op_t a, input issue_op_t b);
        return a.valid && b.valid && (a.rd != '0)
            && ((b.rs1 == a.rd) || (!b.use_imm && (b.rs2 == a.rd)));
    endfunction

    task automatic log_problem(input string msg);
        $display("ERROR: %s", msg);
        other_errs++;
    endtask

    task automatic log_mismatch(
        input string       name,
        input string       what,
        input logic [31:0] exp_val,
        input logic [31:0] act_val
    );
        $display("FAILED %s %s: expected %08h, actual %08h", name, what, exp_val, act_val);
        value_errs++;
    endtask

    task automatic load_stimulus;
        int         fd;
        int         cnt;
        string      line;
        string      name;
        logic       chain;
        logic       v0;
        logic       v1;
        logic       ui0;
        logic       ui1;
        logic [2:0] op0;
        logic [2:0] op1;
        reg_addr_t  rd0;
        reg_addr_t  rs10;
        reg_addr_t  rs20;
        reg_addr_t  rd1;
        reg_addr_t  rs11;
        reg_addr_t  rs21;
        word_t      imm0;
        word_t      imm1;
        word_t      e0;
        word_t      e1;
        fd = $fopen("test/dual_stimulus.txt", "r");
        if (fd == 0) begin
            log_problem("cannot open test/dual_stimulus.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;
                end
                cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %h %d %d %d %d %d %d %h %h %h",
                              name, chain, v0, op0, ui0, rd0, rs10, rs20, imm0,
                              v1, op1, ui1, rd1, rs11, rs21, imm1, e0, e1);
                if (cnt != 18) begin
                    log_problem({"malformed stimulus line: ", line});
                    continue;
                end
                line_name.push_back(name);
                line_chain.push_back(chain);
                line_op0.push_back(make_op(v0, op0, ui0, rd0, rs10, rs20, imm0));
                line_op1.push_back(make_op(v1, op1, ui1, rd1, rs11, rs21, imm1));
                if (v0) begin
                    exp_q.push_back('{en: 1'b1, addr: rd0, data: e0});
                    exp_name.push_back(name);
                    exp_slot.push_back(0);
                end
                if (v1) begin
                    exp_q.push_back('{en: 1'b1, addr: rd1, data: e1});
                    exp_name.push_back(name);
                    exp_slot.push_back(1);
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic apply_reset;
        repeat (5) begin
            @(negedge clk);
            assert (!wb_0.en && !wb_1.en && !hold)
                else log_problem("writeback strobe or hold high during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!wb_0.en && !wb_1.en && !hold)
            else log_problem("writeback strobe or hold high right after reset");
    endtask

    task automatic drive_line(input int idx);
        int gap;
        int holds;
        int want;
        gap   = line_chain[idx] ? 0 : int'($urandom % 4);
        want  = splits(line_op0[idx], line_op1[idx]) ? 1 : 0;
        holds = 0;
        repeat (gap) begin
            @(posedge clk);
            in_op_0 <= '0;
            in_op_1 <= '0;
            @(negedge clk);
            assert (!hold) else log_problem("hold high while no pair is offered");
        end
        @(posedge clk);
        in_op_0 <= line_op0[idx];
        in_op_1 <= line_op1[idx];
        @(negedge clk);
        while (hold) begin   // pair stays until taken
            holds++;
            @(negedge clk);
        end
        assert (holds == want) else log_mismatch(line_name[idx], "hold cycles", want, holds);
    endtask

    task automatic check_writebacks;
        int n;
        n = (seen.size() < exp_q.size()) ? seen.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            assert (seen[i].addr == exp_q[i].addr)
                else log_mismatch(exp_name[i], $sformatf("slot %0d rd", exp_slot[i]),
                                  32'(exp_q[i].addr), 32'(seen[i].addr));
            assert (seen[i].data == exp_q[i].data)
                else log_mismatch(exp_name[i], $sformatf("slot %0d data", exp_slot[i]),
                                  exp_q[i].data, seen[i].data);
        end
        assert (seen.size() == exp_q.size())
            else log_problem($sformatf("expected %0d writebacks but the DUT made %0d",
                                       exp_q.size(), seen.size()));
    endtask

    initial begin
        wait (loaded);
        repeat (line_name.size() * 8 + 50) @(posedge clk);
        $display("timeout: the run did not finish within the watchdog limit");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_op_0    = '0;
        in_op_1    = '0;
        value_errs = 0;
        other_errs = 0;
        loaded     = 1'b0;
        void'($urandom(93435));
        load_stimulus();
        apply_reset();
        for (int i = 0; i < line_name.size(); i++) begin
            drive_line(i);
        end
        @(posedge clk);
        in_op_0 <= '0;
        in_op_1 <= '0;
        while (seen.size() < exp_q.size()) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);   // catch stray strobes
        check_writebacks();
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- test/dual_stimulus.txt
# name chain | slot0: valid op use_imm rd rs1 rs2 imm | slot1: same | exp0 exp1 (imm, exp in hex)
# op 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sll 7 srl; chain 1 means no idle gap before the line
rst_read      0  1 0 0  1  5  6 00000000  1 3 0  2  7  8 00000000  00000000 00000000
imm_load_a    0  1 0 1  1  0  0 12345678  1 0 1  2  0  0 0000000f  12345678 0000000f
imm_load_b    0  1 0 1  3  0  0 80000001  1 0 1  4  0  0 fffffff0  80000001 fffffff0
alu_add_sub   0  1 0 0  5  1  2 00000000  1 1 0  6  1  2 00000000  12345687 12345669
alu_and_or    0  1 2 0  7  3  4 00000000  1 3 0  8  3  4 00000000  80000000 fffffff1
alu_xor_slt   0  1 4 0  9  1  4 00000000  1 5 0 10  3  1 00000000  edcba988 00000001
alu_slt_sll   0  1 5 0 11  1  3 00000000  1 6 1 12  2  0 00000004  00000000 000000f0
alu_srl_sub   0  1 7 0 13  3  2 00000000  1 1 0 14  0  2 00000000  00010000 fffffff1
alu_shamt_imm 0  1 6 1 15  2  0 00000024  1 2 1 16  4  0 0000ff00  000000f0 0000ff00
fwd_seed      0  1 0 1 17  1  0 00000001  1 0 1 18  2  0 00000001  12345679 00000010
fwd_ex        1  1 0 0 19 17 18 00000000  1 1 0 20 18 17 00000000  12345689 edcba997
fwd_ex_rf     1  1 0 0 21 19 17 00000000  1 2 0 22 20 18 00000000  2468ad02 00000010
same_rd       0  1 0 1 23  0  0 00000aaa  1 0 1 23  0  0 00000bbb  00000aaa 00000bbb
same_rd_fwd   1  1 0 1 24 23  0 00000000  1 3 0 25 23  0 00000000  00000bbb 00000bbb
same_rd_read  0  1 0 1 26 23  0 00000000  0 0 0  0  0  0 00000000  00000bbb 00000000
x0_write      0  1 0 1  0  1  0 00000000  1 0 1  0  2  0 00000000  12345678 0000000f
x0_fwd_read   1  1 0 0 27  0  1 00000000  1 3 0 28  0  0 00000000  12345678 00000000
x0_late_read  0  1 0 1 29  0  0 00000005  1 4 0 30  0  2 00000000  00000005 0000000f
split_rs1     0  1 0 1  1  2  0 00000001  1 0 1  2  1  0 00000001  00000010 00000011
split_rs2     1  1 0 0  3  1  2 00000000  1 1 0  4  2  3 00000000  00000021 fffffff0
split_fwd     1  1 6 1  5  3  0 00000004  1 0 0  6  5  5 00000000  00000210 00000420
imm_no_split  0  1 0 1  7  0  0 00000007  1 0 1  8  1  7 00000007  00000007 00000017
x0_no_split   0  1 0 1  0  1  0 00000000  1 0 1  9  0  0 00000003  00000010 00000003
inv_no_split  0  0 0 0 10  0  0 00000000  1 0 1 11 10  0 00000001  00000000 00000002
split_after   1  1 0 0 12 11 11 00000000  1 0 1 13 12  0 00000000  00000004 00000004
same_rd_sum   0  1 0 0 15 23  0 00000000  1 0 0 16 24 25 00000000  00000bbb 00001776
x0_sum        0  1 3 0 17  0  0 00000000  1 0 0 18 29 30 00000000  00000000 00000014
all_idle      0  0 0 0  0  0  0 00000000  0 0 0  0  0  0 00000000  00000000 00000000
srl_slt_neg   0  1 7 1 19  4  0 0000001c  1 5 0 20  4  0 00000000  0000000f 00000001

//--- tb.f
+incdir+rtl
rtl/dual_pkg.sv
rtl/int_alu.sv
rtl/regfile.sv
rtl/pair_issue.sv
rtl/operand_bypass.sv
rtl/exec_stage.sv
rtl/dual_issue_core.sv
test/tb_dual_issue.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_dual_issue \
    -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    && grep -q "^Finished with no errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
